// File: rtl/ncpu64k_pkg.sv
// ********************
// Shared widths and port counts of the
// physical register file subsystem
// Init sequencer state encoding
// ********************

package ncpu64k_pkg;

   // Data word width of one physical register
   localparam int DW = 64;

   // Physical register address width
   localparam int PRF_AW = 6;

   // Number of physical registers
   localparam int PRF_DEPTH = 1 << PRF_AW;

   // Instructions issued per cycle
   localparam int IW = 2;

   // Two source operands per issued instruction
   localparam int NUM_READ = 2 * IW;

   // Write lanes coming from the execution pipes
   // Lane 0 is shared with the LSU and the clearing sequencer
   localparam int CW = 2;

   // Clearing sequencer states
   // INIT_IDLE   one settling cycle after reset
   // INIT_CLEAR  one register zeroed per cycle
   // INIT_DONE   array known zero, normal traffic
   typedef enum logic [1:0]
   {
      INIT_IDLE  = 2'b00,
      INIT_CLEAR = 2'b01,
      INIT_DONE  = 2'b10
   } init_state_t;

endpackage

// File: rtl/prf_mem.sv
// ********************
// Physical register array
// NUM_READ registered read ports
// CW write ports, highest lane wins
// ********************

`timescale 1ns/100ps

module prf_mem
(
   input  logic                                               clk,

   // Read operand stage
   input  logic [ncpu64k_pkg::NUM_READ-1:0]                   rd_re,
   input  logic [ncpu64k_pkg::NUM_READ*ncpu64k_pkg::PRF_AW-1:0] rd_addr,
   output logic [ncpu64k_pkg::NUM_READ*ncpu64k_pkg::DW-1:0]   rd_data,

   // Arbitrated write lanes
   input  logic [ncpu64k_pkg::CW-1:0]                         mem_we,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PRF_AW-1:0]     mem_addr,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]         mem_data
);
   import ncpu64k_pkg::*;

   // Register storage
   // Zeroed by the init sequencer after reset
   logic [DW-1:0]     regs [PRF_DEPTH];

   // Per-lane views of the packed buses
   logic [PRF_AW-1:0] wr_idx [CW];
   logic [DW-1:0]     wr_val [CW];
   logic [PRF_AW-1:0] rd_idx [NUM_READ];

   always_comb
   begin
      for (int i = 0; i < CW; i++)
      begin
         wr_idx[i] = mem_addr[i*PRF_AW +: PRF_AW];
         wr_val[i] = mem_data[i*DW +: DW];
      end
      for (int j = 0; j < NUM_READ; j++)
      begin
         rd_idx[j] = rd_addr[j*PRF_AW +: PRF_AW];
      end
   end

   // Write ports
   // Ascending lane order, so on an address collision
   // the last (highest) lane's assignment is the one kept
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < CW; i++)
      begin
         if (mem_we[i])
            regs[wr_idx[i]] <= wr_val[i];
      end
   end

   // Read ports
   // Data captured at the edge that samples rd_re
   // Same-edge write not visible yet, old value returned
   // Port holds its last value while rd_re is low
   always_ff @(posedge clk)
   begin
      for (int j = 0; j < NUM_READ; j++)
      begin
         if (rd_re[j])
            rd_data[j*DW +: DW] <= regs[rd_idx[j]];
      end
   end

endmodule

// File: rtl/wb_arbiter.sv
// ********************
// Write-back arbiter
// Clearing, LSU and pipe lane 0 onto array lane 0
// Upper pipe lanes passed through
// ********************

`timescale 1ns/100ps

module wb_arbiter
(
   // Init sequencer
   input  logic                                           busy,
   input  logic                                           clr_we,
   input  logic [ncpu64k_pkg::PRF_AW-1:0]                 clr_addr,

   // Execution pipes
   input  logic [ncpu64k_pkg::CW-1:0]                     wr_we,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PRF_AW-1:0] wr_addr,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]     wr_data,

   // LSU, no ready of its own
   input  logic                                           lsu_we,
   input  logic [ncpu64k_pkg::PRF_AW-1:0]                 lsu_addr,
   input  logic [ncpu64k_pkg::DW-1:0]                     lsu_data,

   // Array write lanes
   output logic [ncpu64k_pkg::CW-1:0]                     mem_we,
   output logic [ncpu64k_pkg::CW*ncpu64k_pkg::PRF_AW-1:0] mem_addr,
   output logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]     mem_data,

   // Back to the pipes
   output logic [ncpu64k_pkg::CW-1:0]                     wb_ready
);
   import ncpu64k_pkg::*;

   always_comb
   begin
      // Default: every pipe lane straight through
      // Nothing from the pipes while the array is being cleared
      mem_we   = wr_we & {CW{~busy}};
      mem_addr = wr_addr;
      mem_data = wr_data;
      wb_ready = {CW{~busy}};

      // Lane 0 priority: clearing, then LSU, then pipe 0
      if (busy)
      begin
         mem_we[0]             = clr_we;
         mem_addr[0 +: PRF_AW] = clr_addr;
         mem_data[0 +: DW]     = '0;
         wb_ready[0]           = 1'b0;
      end
      else if (lsu_we)
      begin
         // Pipe 0 stalled, holds its request until a free cycle
         mem_we[0]             = 1'b1;
         mem_addr[0 +: PRF_AW] = lsu_addr;
         mem_data[0 +: DW]     = lsu_data;
         wb_ready[0]           = 1'b0;
      end
   end

endmodule

// File: rtl/prf_init_fsm.sv
// ********************
// Post-reset clearing sequencer
// State machine, address counter, done flag
// ********************

`timescale 1ns/100ps

module prf_init_fsm
(
   input  logic                           clk,
   input  logic                           rst_n,
   output logic                           clr_we,
   output logic [ncpu64k_pkg::PRF_AW-1:0] clr_addr,
   output logic                           busy,
   output logic                           init_done
);
   import ncpu64k_pkg::*;

   init_state_t state_q;
   init_state_t state_d;

   // Counter at the top register, walk ends this cycle
   logic        last_addr;

   assign last_addr = (clr_addr == PRF_AW'(PRF_DEPTH - 1));

   // Next state
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         // One idle cycle after reset release
         INIT_IDLE:
            state_d = INIT_CLEAR;
         INIT_CLEAR:
         begin
            if (last_addr)
               state_d = INIT_DONE;
         end
         // Stays here until the next reset
         INIT_DONE:
            state_d = INIT_DONE;
         default:
            state_d = INIT_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= INIT_IDLE;
      else
         state_q <= state_d;
   end

   // Clearing address, one register per cycle
   // Wraps back to 0 after the last one
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         clr_addr <= '0;
      else if (clr_we)
         clr_addr <= clr_addr + 1'b1;
   end

   // Outputs decoded from state
   assign clr_we    = (state_q == INIT_CLEAR);
   // Idle and clearing both block other writers
   assign busy      = (state_q != INIT_DONE);
   assign init_done = (state_q == INIT_DONE);

endmodule

// File: rtl/ncpu64k.sv
// ********************
// Register file subsystem top
// Init sequencer, write-back arbiter, array
// ********************

`timescale 1ns/100ps

module ncpu64k
(
   input  logic                                                 clk,
   input  logic                                                 rst_n,

   // Read operand stage
   input  logic [ncpu64k_pkg::NUM_READ-1:0]                     rd_re,
   input  logic [ncpu64k_pkg::NUM_READ*ncpu64k_pkg::PRF_AW-1:0] rd_addr,
   output logic [ncpu64k_pkg::NUM_READ*ncpu64k_pkg::DW-1:0]     rd_data,

   // Execution pipe write-back
   input  logic [ncpu64k_pkg::CW-1:0]                           wr_we,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::PRF_AW-1:0]       wr_addr,
   input  logic [ncpu64k_pkg::CW*ncpu64k_pkg::DW-1:0]           wr_data,

   // LSU write-back
   input  logic                                                 lsu_we,
   input  logic [ncpu64k_pkg::PRF_AW-1:0]                       lsu_addr,
   input  logic [ncpu64k_pkg::DW-1:0]                           lsu_data,

   // Write accepted per pipe lane
   output logic [ncpu64k_pkg::CW-1:0]                           wb_ready,
   // Array cleared, normal traffic allowed
   output logic                                                 init_done
);
   import ncpu64k_pkg::*;

   // Sequencer to arbiter
   logic                 clr_we;
   logic [PRF_AW-1:0]    clr_addr;
   logic                 busy;

   // Arbiter to array
   logic [CW-1:0]        mem_we;
   logic [CW*PRF_AW-1:0] mem_addr;
   logic [CW*DW-1:0]     mem_data;

   prf_init_fsm U_INIT
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .clr_we    (clr_we),
      .clr_addr  (clr_addr),
      .busy      (busy),
      .init_done (init_done)
   );

   // Lane 0 shared by clearing, LSU and pipe 0
   wb_arbiter U_ARB
   (
      .busy      (busy),
      .clr_we    (clr_we),
      .clr_addr  (clr_addr),
      .wr_we     (wr_we),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .lsu_we    (lsu_we),
      .lsu_addr  (lsu_addr),
      .lsu_data  (lsu_data),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_data  (mem_data),
      .wb_ready  (wb_ready)
   );

   // No read bypass, write visible one edge later
   prf_mem U_PRF
   (
      .clk       (clk),
      .rd_re     (rd_re),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_data  (mem_data)
   );

endmodule

// File: testbench/ncpu64k_sva.sv
// ********************
// Concurrent assertions on the subsystem top
// Init blocking, LSU timing, lane 0 priority
// Bound to ncpu64k
// ********************

`timescale 1ns/100ps

module ncpu64k_sva
(
   input logic                         clk,
   input logic                         rst_n,
   input logic                         lsu_we,
   input logic [ncpu64k_pkg::CW-1:0]   wb_ready,
   input logic                         init_done
);

   // Failed assertion count, read back by the testbench
   int fail_count = 0;

   // Pipes blocked until the array is known zero
   no_ready_before_init: assert property (@(posedge clk) disable iff (!rst_n)
      !init_done |-> (wb_ready == '0))
   else
   begin
      fail_count++;
      $error("wb_ready high while init_done low");
   end

   // LSU has no ready, so it must wait for the clearing walk
   no_lsu_before_init: assert property (@(posedge clk) disable iff (!rst_n)
      !init_done |-> !lsu_we)
   else
   begin
      fail_count++;
      $error("lsu_we high while init_done low");
   end

   // Done is sticky until the next reset
   init_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      init_done |=> init_done)
   else
   begin
      fail_count++;
      $error("init_done fell without reset");
   end

   // LSU owns lane 0, pipe 0 stalled
   lsu_stalls_lane0: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_we |-> !wb_ready[0])
   else
   begin
      fail_count++;
      $error("wb_ready[0] high during an LSU write");
   end

endmodule

bind ncpu64k ncpu64k_sva U_SVA
(
   .clk       (clk),
   .rst_n     (rst_n),
   .lsu_we    (lsu_we),
   .wb_ready  (wb_ready),
   .init_done (init_done)
);

// File: testbench/ncpu64k_tb.sv
// ********************
// Testbench for the register file subsystem
// Clock, reset, random and directed stimulus
// Reference model and per-cycle comparison
// ********************

`timescale 1ns/100ps

module ncpu64k_tb;
   import ncpu64k_pkg::*;

   logic                   clk;
   logic                   rst_n;
   logic [NUM_READ-1:0]    rd_re;
   logic [NUM_READ*PRF_AW-1:0] rd_addr;
   logic [NUM_READ*DW-1:0] rd_data;
   logic [CW-1:0]          wr_we;
   logic [CW*PRF_AW-1:0]   wr_addr;
   logic [CW*DW-1:0]       wr_data;
   logic                   lsu_we;
   logic [PRF_AW-1:0]      lsu_addr;
   logic [DW-1:0]          lsu_data;
   logic [CW-1:0]          wb_ready;
   logic                   init_done;

   // Model state, owned by the comparison process
   logic [DW-1:0]          ref_regs [PRF_DEPTH];
   logic [DW-1:0]          exp_rd [NUM_READ];
   logic [NUM_READ-1:0]    exp_valid;
   logic [CW-1:0]          acc_mask;
   logic                   model_on;
   integer                 seed;

   ncpu64k DUT
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_re     (rd_re),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .wr_we     (wr_we),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .lsu_we    (lsu_we),
      .lsu_addr  (lsu_addr),
      .lsu_data  (lsu_data),
      .wb_ready  (wb_ready),
      .init_done (init_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_eq(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                           input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
         fail_run("stopping at the first mismatch");
      end
   endtask

   function automatic logic [DW-1:0] rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // One cycle of write requests, DUT idle of clearing
   // Returns the expected wb_ready
   function automatic logic [CW-1:0] ref_write
   (
      input logic [CW-1:0]        we,
      input logic [CW*PRF_AW-1:0] addr,
      input logic [CW*DW-1:0]     data,
      input logic                 l_we,
      input logic [PRF_AW-1:0]    l_addr,
      input logic [DW-1:0]        l_data
   );
      logic [CW-1:0] ready;
      ready = '1;
      // LSU takes lane 0, pipe 0 stalls
      if (l_we)
      begin
         ready[0] = 1'b0;
         ref_regs[l_addr] = l_data;
      end
      else if (we[0])
         ref_regs[addr[0 +: PRF_AW]] = data[0 +: DW];
      // Upper lanes applied later, so they win a collision
      for (int i = 1; i < CW; i++)
      begin
         if (we[i])
            ref_regs[addr[i*PRF_AW +: PRF_AW]] = data[i*DW +: DW];
      end
      return ready;
   endfunction

   // Comparison at the falling edge, all outputs settled
   always @(negedge clk)
   begin : compare_cycle
      logic [CW-1:0] ready;
      if (model_on)
      begin
         for (int j = 0; j < NUM_READ; j++)
         begin
            if (exp_valid[j])
               check_eq(rd_data[j*DW +: DW], exp_rd[j], $sformatf("rd_data port %0d", j));
         end
         // Reads sampled at the coming edge see pre-write contents
         for (int j = 0; j < NUM_READ; j++)
         begin
            if (rd_re[j])
            begin
               exp_rd[j]    = ref_regs[rd_addr[j*PRF_AW +: PRF_AW]];
               exp_valid[j] = 1'b1;
            end
         end
         ready = ref_write(wr_we, wr_addr, wr_data, lsu_we, lsu_addr, lsu_data);
         check_eq(DW'(wb_ready), DW'(ready), "wb_ready");
         acc_mask = ready & wr_we;
      end
      else
      begin
         // Array fully cleared once init_done is up
         for (int a = 0; a < PRF_DEPTH; a++)
            ref_regs[a] = '0;
         exp_valid = '0;
         acc_mask  = '0;
      end
   end

   task automatic idle_cycle();
      @(posedge clk);
      rd_re  <= '0;
      wr_we  <= '0;
      lsu_we <= 1'b0;
   endtask

   task automatic wait_init_done();
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < 4 * PRF_DEPTH && !seen; n++)
      begin
         @(negedge clk);
         if (init_done)
            seen = 1'b1;
         else
            check_eq(DW'(wb_ready), '0, "wb_ready before init_done");
      end
      if (!seen)
         fail_run("init_done did not rise after reset");
   endtask

   // Taken at the edge after wb_ready[0] is seen high
   task automatic wait_lane0_accept();
      bit taken;
      taken = 1'b0;
      for (int n = 0; n < 16 && !taken; n++)
      begin
         @(negedge clk);
         taken = wb_ready[0];
      end
      if (!taken)
         fail_run("held pipe lane 0 write was never accepted");
      @(posedge clk);
      wr_we[0] <= 1'b0;
   endtask

   // Single read on one port, value checked directly
   task automatic read_expect(input int port, input logic [PRF_AW-1:0] addr,
                              input logic [DW-1:0] value, input string what);
      logic [NUM_READ-1:0] m;
      m = '0;
      m[port] = 1'b1;
      @(posedge clk);
      rd_re <= m;
      rd_addr[port*PRF_AW +: PRF_AW] <= addr;
      @(posedge clk);
      rd_re <= '0;
      @(negedge clk);
      check_eq(rd_data[port*DW +: DW], value, what);
   endtask

   // Every register on all ports at once
   task automatic clear_readback();
      logic [NUM_READ*PRF_AW-1:0] addrs;
      for (int a = 0; a < PRF_DEPTH; a++)
      begin
         @(posedge clk);
         for (int j = 0; j < NUM_READ; j++)
            addrs[j*PRF_AW +: PRF_AW] = PRF_AW'(a);
         rd_re   <= '1;
         rd_addr <= addrs;
      end
   endtask

   task automatic random_cycle(input bit with_lsu);
      logic [31:0]          r;
      logic [CW-1:0]        nw_we;
      logic [CW*PRF_AW-1:0] nw_addr;
      logic [CW*DW-1:0]     nw_data;
      @(posedge clk);
      r = $random(seed);
      rd_re <= r[NUM_READ-1:0];
      r = $random(seed);
      rd_addr <= r[NUM_READ*PRF_AW-1:0];
      r = $random(seed);
      nw_we   = r[CW-1:0];
      nw_addr = r[CW +: CW*PRF_AW];
      for (int i = 0; i < CW; i++)
         nw_data[i*DW +: DW] = rand_word();
      // Stalled lane 0 keeps its request
      if (wr_we[0] && !acc_mask[0])
      begin
         nw_we[0]             = 1'b1;
         nw_addr[0 +: PRF_AW] = wr_addr[0 +: PRF_AW];
         nw_data[0 +: DW]     = wr_data[0 +: DW];
      end
      wr_we   <= nw_we;
      wr_addr <= nw_addr;
      wr_data <= nw_data;
      r = $random(seed);
      lsu_we   <= with_lsu && (r[1:0] == 2'b00);
      lsu_addr <= r[2 +: PRF_AW];
      lsu_data <= rand_word();
   endtask

   task automatic lsu_priority_test();
      logic [DW-1:0] d_pipe;
      logic [DW-1:0] d_lsu;
      d_pipe = rand_word();
      d_lsu  = rand_word();
      @(posedge clk);
      wr_we                <= CW'(1);
      wr_addr[0 +: PRF_AW] <= PRF_AW'(10);
      wr_data[0 +: DW]     <= d_pipe;
      lsu_we               <= 1'b1;
      lsu_addr             <= PRF_AW'(20);
      lsu_data             <= d_lsu;
      @(negedge clk);
      check_eq(DW'(wb_ready[0]), '0, "wb_ready[0] during LSU write");
      // LSU held a second cycle
      @(posedge clk);
      @(posedge clk);
      lsu_we <= 1'b0;
      wait_lane0_accept();
      read_expect(0, PRF_AW'(20), d_lsu, "LSU write under contention");
      read_expect(1, PRF_AW'(10), d_pipe, "held pipe lane 0 write");
   endtask

   task automatic collision_test();
      logic [PRF_AW-1:0] c;
      logic [DW-1:0]     d0;
      logic [DW-1:0]     d1;
      c  = PRF_AW'(45);
      d0 = rand_word();
      d1 = rand_word();
      @(posedge clk);
      wr_we   <= '1;
      wr_addr <= {CW{c}};
      wr_data <= {d1, d0};
      // Same-edge read returns the old value
      rd_re   <= NUM_READ'(2);
      rd_addr[PRF_AW +: PRF_AW] <= c;
      @(posedge clk);
      wr_we <= '0;
      rd_re <= '0;
      read_expect(1, c, d1, "lane 1 over pipe lane 0");
      d0 = rand_word();
      d1 = rand_word();
      @(posedge clk);
      lsu_we   <= 1'b1;
      lsu_addr <= c;
      lsu_data <= d0;
      wr_we    <= CW'(2);
      wr_addr[PRF_AW +: PRF_AW] <= c;
      wr_data[DW +: DW]         <= d1;
      @(posedge clk);
      lsu_we <= 1'b0;
      wr_we  <= '0;
      read_expect(3, c, d1, "lane 1 over LSU");
   endtask

   task automatic read_hold_test();
      logic [DW-1:0] v_old;
      logic [DW-1:0] v_new;
      v_old = rand_word();
      @(posedge clk);
      wr_we <= CW'(2);
      wr_addr[PRF_AW +: PRF_AW] <= PRF_AW'(33);
      wr_data[DW +: DW]         <= v_old;
      @(posedge clk);
      wr_we <= '0;
      read_expect(2, PRF_AW'(33), v_old, "read before hold");
      // Rewrite while rd_re stays low
      for (int k = 0; k < 4; k++)
      begin
         @(posedge clk);
         v_new = rand_word();
         wr_we <= CW'(2);
         wr_data[DW +: DW] <= v_new;
         @(negedge clk);
         check_eq(rd_data[2*DW +: DW], v_old, "rd_data held while rd_re low");
      end
      @(posedge clk);
      wr_we <= '0;
      read_expect(2, PRF_AW'(33), v_new, "read after hold");
   endtask

   initial
   begin
      seed     = 32'h3f86c946;
      model_on = 1'b0;
      rst_n    = 1'b0;
      rd_re    = '0;
      rd_addr  = '0;
      wr_we    = '0;
      wr_addr  = '0;
      wr_data  = '0;
      lsu_we   = 1'b0;
      lsu_addr = '0;
      lsu_data = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      wait_init_done();
      @(posedge clk);
      model_on = 1'b1;
      clear_readback();
      idle_cycle();

      // Pipes only, then with LSU back-pressure
      repeat (300) random_cycle(1'b0);
      repeat (300) random_cycle(1'b1);
      // One cycle without LSU so a stalled lane 0 drains
      random_cycle(1'b0);
      idle_cycle();

      lsu_priority_test();
      collision_test();
      read_hold_test();
      repeat (3) idle_cycle();

      if (DUT.U_SVA.fail_count == 0)
      begin
         $display("test passed");
         $finish;
      end
      else
         fail_run("bound assertions reported failures");
   end

endmodule

// File: ncpu64k.f
rtl/ncpu64k_pkg.sv
rtl/prf_mem.sv
rtl/wb_arbiter.sv
rtl/prf_init_fsm.sv
rtl/ncpu64k.sv
testbench/ncpu64k_sva.sv
testbench/ncpu64k_tb.sv
